/* design/excp_cause_decoder.sv */
// excp_cause_decoder: priority encoder from exception flags to cause code and tval source
`timescale 1ns/100ps

module excp_cause_decoder import trap_pkg::*; (
  input  exc_flags_t    flags,
  output exc_decision_t decision
);

  logic [EXC_FLAGS_W-1:0] flag_vec;

  assign flag_vec = flags;

  always_comb begin
    decision.valid    = |flag_vec;
    decision.code     = EXC_INST_MISAL;
    decision.tval_src = TVAL_ZERO;
    // fetch side faults first, then decode, then memory side
    if (flags.inst_page) begin
      decision.code     = EXC_INST_PAGE;
      decision.tval_src = TVAL_PC;
    end else if (flags.inst_acc) begin
      decision.code     = EXC_INST_ACC;
      decision.tval_src = TVAL_PC;
    end else if (flags.inst_misal) begin
      decision.code     = EXC_INST_MISAL;
      decision.tval_src = TVAL_PC;
    end else if (flags.ilg_inst) begin
      decision.code     = EXC_ILG_INST;
      decision.tval_src = TVAL_INST;
    end else if (flags.brk_pt) begin
      decision.code     = EXC_BRK_PT;
      decision.tval_src = TVAL_ZERO;
    end else if (flags.ecall_m) begin
      decision.code     = EXC_ECALL_M;
      decision.tval_src = TVAL_ZERO;
    end else if (flags.stor_page) begin
      decision.code     = EXC_STOR_PAGE;
      decision.tval_src = TVAL_ADDR;
    end else if (flags.load_page) begin
      decision.code     = EXC_LOAD_PAGE;
      decision.tval_src = TVAL_ADDR;
    end else if (flags.stor_acc) begin
      decision.code     = EXC_STOR_ACC;
      decision.tval_src = TVAL_ADDR;
    end else if (flags.load_acc) begin
      decision.code     = EXC_LOAD_ACC;
      decision.tval_src = TVAL_ADDR;
    end else if (flags.stor_misal) begin
      decision.code     = EXC_STOR_MISAL;
      decision.tval_src = TVAL_ADDR;
    end else if (flags.load_misal) begin
      decision.code     = EXC_LOAD_MISAL;
      decision.tval_src = TVAL_ADDR;
    end
  end

endmodule

/* design/itrp_arbiter.sv */
// itrp_arbiter: masks pending interrupts with mie and mstatus.MIE, picks the winner
`timescale 1ns/100ps

module itrp_arbiter import trap_pkg::*; (
  input  csr_view_t      csrs,
  output itrp_decision_t decision
);

  logic global_en;
  logic soft_en;
  logic timer_en;
  logic exter_en;

  assign global_en = csrs.mstatus[MSTATUS_MIE_BIT];

  // pending and enabled per line
  assign soft_en  = global_en & csrs.mip[MSI_BIT] & csrs.mie[MSI_BIT];
  assign timer_en = global_en & csrs.mip[MTI_BIT] & csrs.mie[MTI_BIT];
  assign exter_en = global_en & csrs.mip[MEI_BIT] & csrs.mie[MEI_BIT];

  always_comb begin
    decision.valid = soft_en | timer_en | exter_en;
    decision.code  = '0;
    // external beats soft beats timer
    if (exter_en) begin
      decision.code = ITRP_EXTER;
    end else if (soft_en) begin
      decision.code = ITRP_SOFT;
    end else if (timer_en) begin
      decision.code = ITRP_TIMER;
    end
  end

endmodule

/* design/machine_csr_file.sv */
// machine_csr_file: mstatus, mtvec, mepc, mcause, mtval, mie and mip with software and trap ports
`timescale 1ns/100ps

module machine_csr_file import trap_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ITRP_W-1:0] irq,
  input  logic              csr_we,
  input  logic [11:0]       csr_addr,
  input  logic [XLEN-1:0]   csr_wdata,
  input  csr_trap_wr_t      trap_wr,
  output logic [XLEN-1:0]   csr_rdata,
  output csr_view_t         csrs
);

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mtval_q;
  logic [XLEN-1:0] mie_q;
  logic [XLEN-1:0] mip_q;
  logic [XLEN-1:0] mip_d;

  logic sw_mstatus;
  logic sw_mtvec;
  logic sw_mepc;
  logic sw_mcause;
  logic sw_mtval;
  logic sw_mie;
  logic trap_status;

  assign sw_mstatus  = csr_we && (csr_addr == CSR_MSTATUS);
  assign sw_mtvec    = csr_we && (csr_addr == CSR_MTVEC);
  assign sw_mepc     = csr_we && (csr_addr == CSR_MEPC);
  assign sw_mcause   = csr_we && (csr_addr == CSR_MCAUSE);
  assign sw_mtval    = csr_we && (csr_addr == CSR_MTVAL);
  assign sw_mie      = csr_we && (csr_addr == CSR_MIE);
  assign trap_status = trap_wr.enter || trap_wr.ret;

  // irq order is soft, timer, external
  always_comb begin
    mip_d          = '0;
    mip_d[MSI_BIT] = irq[0];
    mip_d[MTI_BIT] = irq[1];
    mip_d[MEI_BIT] = irq[2];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mie_q     <= '0;
      mip_q     <= '0;
    end else begin
      mip_q <= mip_d;
      // trap update has priority over software
      if (trap_status) begin
        mstatus_q <= trap_wr.mstatus;
      end else if (sw_mstatus) begin
        mstatus_q <= csr_wdata;
      end
      if (sw_mtvec) begin
        mtvec_q <= csr_wdata;
      end
      if (sw_mie) begin
        mie_q <= csr_wdata;
      end
    end
  end

  // trap entry registers
  always_ff @(posedge clk) begin
    if (trap_wr.enter) begin
      mepc_q   <= trap_wr.mepc;
      mcause_q <= trap_wr.mcause;
      mtval_q  <= trap_wr.mtval.addr;
    end else begin
      if (sw_mepc) begin
        mepc_q <= csr_wdata;
      end
      if (sw_mcause) begin
        mcause_q <= csr_wdata;
      end
      if (sw_mtval) begin
        mtval_q <= csr_wdata;
      end
    end
  end

  always_comb begin
    case (csr_addr)
      CSR_MSTATUS: csr_rdata = mstatus_q;
      CSR_MTVEC:   csr_rdata = mtvec_q;
      CSR_MEPC:    csr_rdata = mepc_q;
      CSR_MCAUSE:  csr_rdata = mcause_q;
      CSR_MTVAL:   csr_rdata = mtval_q;
      CSR_MIE:     csr_rdata = mie_q;
      CSR_MIP:     csr_rdata = mip_q;
      default:     csr_rdata = '0;
    endcase
  end

  // read view for the decision logic
  always_comb begin
    csrs.mstatus = mstatus_q;
    csrs.mtvec   = mtvec_q;
    csrs.mepc    = mepc_q;
    csrs.mie     = mie_q;
    csrs.mip     = mip_q;
  end

endmodule

/* design/trap_controller.sv */
// trap_controller: four-phase handshake FSM, trap csr update and redirect generation
`timescale 1ns/100ps

module trap_controller import trap_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req,
  input  trap_req_t       trap,
  input  exc_decision_t   exc,
  input  itrp_decision_t  itrp,
  input  csr_view_t       csrs,
  output logic            ack,
  output logic            redirect_valid,
  output logic [XLEN-1:0] redirect_pc,
  output csr_trap_wr_t    csr_wr
);

  typedef enum logic [1:0] {ST_IDLE, ST_COMMIT, ST_ACK} state_e;

  state_e          state_q;
  logic            enter_q;
  logic            ret_q;
  logic            redirect_valid_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] redirect_pc_q;
  tval_u           mtval_q;

  logic            take_exc;
  logic            take_itrp;
  logic            enter_d;
  logic            ret_d;
  logic [XLEN-1:0] mcause_d;
  logic [XLEN-1:0] mstatus_d;
  logic [XLEN-1:0] tvec_base;
  logic [XLEN-1:0] vec_offset;
  logic [XLEN-1:0] redirect_pc_d;
  tval_u           mtval_d;
  logic            accept;

  assign accept = (state_q == ST_IDLE) && req;

  // combined decision, exception first
  always_comb begin
    take_exc   = exc.valid;
    take_itrp  = !exc.valid && itrp.valid;
    enter_d    = (trap.kind == TRAP_ENTER) && (take_exc || take_itrp);
    ret_d      = (trap.kind == TRAP_RETURN);
    tvec_base  = {csrs.mtvec[XLEN-1:2], 2'b00};
    vec_offset = '0;
    vec_offset[CAUSE_W+1:2] = itrp.code;

    mcause_d = '0;
    mcause_d[XLEN-1] = take_itrp;
    mcause_d[CAUSE_W-1:0] = take_exc ? exc.code : itrp.code;

    mtval_d.addr = '0;
    if (take_exc) begin
      case (exc.tval_src)
        TVAL_PC:   mtval_d.addr = trap.pc;
        TVAL_ADDR: mtval_d.addr = trap.addr;
        TVAL_INST: begin
          mtval_d.inst_view.pad  = '0;
          mtval_d.inst_view.inst = trap.inst;
        end
        default:   mtval_d.addr = '0;
      endcase
    end

    mstatus_d = csrs.mstatus;
    if (ret_d) begin
      mstatus_d[MSTATUS_MIE_BIT]  = csrs.mstatus[MSTATUS_MPIE_BIT];
      mstatus_d[MSTATUS_MPIE_BIT] = 1'b1;
      redirect_pc_d = csrs.mepc;
    end else begin
      mstatus_d[MSTATUS_MPIE_BIT] = csrs.mstatus[MSTATUS_MIE_BIT];
      mstatus_d[MSTATUS_MIE_BIT]  = 1'b0;
      // vectored mode only offsets interrupts
      if (csrs.mtvec[0] && take_itrp) begin
        redirect_pc_d = tvec_base + vec_offset;
      end else begin
        redirect_pc_d = tvec_base;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q          <= ST_IDLE;
      enter_q          <= 1'b0;
      ret_q            <= 1'b0;
      redirect_valid_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req) begin
            state_q <= ST_COMMIT;
            enter_q <= enter_d;
            ret_q   <= ret_d;
          end
        end
        ST_COMMIT: begin
          state_q          <= ST_ACK;
          redirect_valid_q <= enter_q | ret_q;
        end
        ST_ACK: begin
          if (!req) begin
            state_q          <= ST_IDLE;
            redirect_valid_q <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // decision payload, captured once per request
  always_ff @(posedge clk) begin
    if (accept) begin
      mcause_q      <= mcause_d;
      mepc_q        <= trap.pc;
      mtval_q       <= mtval_d;
      mstatus_q     <= mstatus_d;
      redirect_pc_q <= redirect_pc_d;
    end
  end

  always_comb begin
    csr_wr.enter   = (state_q == ST_COMMIT) && enter_q;
    csr_wr.ret     = (state_q == ST_COMMIT) && ret_q;
    csr_wr.mcause  = mcause_q;
    csr_wr.mepc    = mepc_q;
    csr_wr.mtval   = mtval_q;
    csr_wr.mstatus = mstatus_q;
  end

  assign ack            = (state_q == ST_ACK);
  assign redirect_valid = redirect_valid_q;
  assign redirect_pc    = redirect_pc_q;

endmodule

/* design/trap_pkg.sv */
// trap_pkg: widths, csr addresses, bit positions, cause codes, trap structs and tval union
package trap_pkg;

  localparam int XLEN        = 64;
  localparam int EXC_FLAGS_W = 12;
  localparam int ITRP_W      = 3;
  localparam int CAUSE_W     = 4;

  // machine csr addresses
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MIE     = 12'h304;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;
  localparam logic [11:0] CSR_MTVAL   = 12'h343;
  localparam logic [11:0] CSR_MIP     = 12'h344;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSI_BIT          = 3;
  localparam int MTI_BIT          = 7;
  localparam int MEI_BIT          = 11;

  // exception cause codes
  localparam logic [CAUSE_W-1:0] EXC_INST_MISAL = 4'd0;
  localparam logic [CAUSE_W-1:0] EXC_INST_ACC   = 4'd1;
  localparam logic [CAUSE_W-1:0] EXC_ILG_INST   = 4'd2;
  localparam logic [CAUSE_W-1:0] EXC_BRK_PT     = 4'd3;
  localparam logic [CAUSE_W-1:0] EXC_LOAD_MISAL = 4'd4;
  localparam logic [CAUSE_W-1:0] EXC_LOAD_ACC   = 4'd5;
  localparam logic [CAUSE_W-1:0] EXC_STOR_MISAL = 4'd6;
  localparam logic [CAUSE_W-1:0] EXC_STOR_ACC   = 4'd7;
  localparam logic [CAUSE_W-1:0] EXC_ECALL_M    = 4'd11;
  localparam logic [CAUSE_W-1:0] EXC_INST_PAGE  = 4'd12;
  localparam logic [CAUSE_W-1:0] EXC_LOAD_PAGE  = 4'd13;
  localparam logic [CAUSE_W-1:0] EXC_STOR_PAGE  = 4'd15;

  // interrupt cause codes
  localparam logic [CAUSE_W-1:0] ITRP_SOFT  = 4'd3;
  localparam logic [CAUSE_W-1:0] ITRP_TIMER = 4'd7;
  localparam logic [CAUSE_W-1:0] ITRP_EXTER = 4'd11;

  // highest priority first
  typedef struct packed {
    logic inst_page;
    logic inst_acc;
    logic inst_misal;
    logic ilg_inst;
    logic brk_pt;
    logic ecall_m;
    logic stor_page;
    logic load_page;
    logic stor_acc;
    logic load_acc;
    logic stor_misal;
    logic load_misal;
  } exc_flags_t;

  typedef enum logic {TRAP_ENTER = 1'b0, TRAP_RETURN = 1'b1} trap_kind_e;

  typedef struct packed {
    trap_kind_e      kind;
    exc_flags_t      flags;
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
    logic [XLEN-1:0] addr;
  } trap_req_t;

  typedef enum logic [1:0] {TVAL_ZERO, TVAL_PC, TVAL_INST, TVAL_ADDR} tval_src_e;

  typedef struct packed {
    logic               valid;
    logic [CAUSE_W-1:0] code;
    tval_src_e          tval_src;
  } exc_decision_t;

  typedef struct packed {
    logic               valid;
    logic [CAUSE_W-1:0] code;
  } itrp_decision_t;

  typedef struct packed {
    logic [31:0] pad;
    logic [31:0] inst;
  } tval_inst_t;

  // mtval seen as a faulting address or as a zero-extended instruction
  typedef union packed {
    logic [XLEN-1:0] addr;
    tval_inst_t      inst_view;
  } tval_u;

  typedef struct packed {
    logic            enter;
    logic            ret;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mepc;
    tval_u           mtval;
    logic [XLEN-1:0] mstatus;
  } csr_trap_wr_t;

  typedef struct packed {
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
  } csr_view_t;

endpackage

/* design/trap_unit_top.sv */
// trap_unit_top: machine trap unit built from decoder, arbiter, controller and csr file
`timescale 1ns/100ps

module trap_unit_top import trap_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req,
  input  trap_req_t         trap,
  input  logic [ITRP_W-1:0] irq,
  input  logic              csr_we,
  input  logic [11:0]       csr_addr,
  input  logic [XLEN-1:0]   csr_wdata,
  output logic              ack,
  output logic              redirect_valid,
  output logic [XLEN-1:0]   redirect_pc,
  output logic [XLEN-1:0]   csr_rdata
);

  exc_decision_t  exc_dec;
  itrp_decision_t itrp_dec;
  csr_view_t      csrs;
  csr_trap_wr_t   trap_wr;

  excp_cause_decoder u_excp_cause_decoder (
    .flags    (trap.flags),
    .decision (exc_dec)
  );

  itrp_arbiter u_itrp_arbiter (
    .csrs     (csrs),
    .decision (itrp_dec)
  );

  trap_controller u_trap_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (req),
    .trap           (trap),
    .exc            (exc_dec),
    .itrp           (itrp_dec),
    .csrs           (csrs),
    .ack            (ack),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .csr_wr         (trap_wr)
  );

  machine_csr_file u_machine_csr_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .irq       (irq),
    .csr_we    (csr_we),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .trap_wr   (trap_wr),
    .csr_rdata (csr_rdata),
    .csrs      (csrs)
  );

endmodule

/* dv/tb_trap_unit.sv */
// testbench for the machine trap unit: clock, reset, csr and handshake tasks, model, checks
`timescale 1ns/100ps

module tb_trap_unit import trap_pkg::*; ();

  // cause code per flag bit from inst_page at bit 11 down to load_misal at bit 0
  localparam logic [47:0] CODE_TBL = {4'd12, 4'd1, 4'd0, 4'd2, 4'd3, 4'd11,
                                      4'd15, 4'd13, 4'd7, 4'd5, 4'd6, 4'd4};

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req;
  trap_req_t   trap;
  logic [2:0]  irq;
  logic        csr_we;
  logic [11:0] csr_addr;
  logic [63:0] csr_wdata;
  logic        ack;
  logic        redirect_valid;
  logic [63:0] redirect_pc;
  logic [63:0] csr_rdata;
  integer      seed = 32'hb170;
  logic [63:0] base;
  logic [63:0] rd;
  logic [31:0] rnd;
  logic [11:0] flags;
  logic        rv;

  trap_unit_top u_trap_unit_top (.*);

  always #5 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp)
      else stop_with_failure($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // handshake rules on every edge
  assert property (@(posedge clk) disable iff (!rst_n) (ack && !req) |=> !ack)
    else stop_with_failure("ack stayed high after req was dropped");
  assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req))
    else stop_with_failure("ack rose without a pending req");
  assert property (@(posedge clk) disable iff (!rst_n)
                   (ack && $past(ack)) |-> ($stable(redirect_pc) && $stable(redirect_valid)))
    else stop_with_failure("redirect changed while ack was high");

  task automatic wait_ack(input logic level, input int exp_edges);
    int n;
    n = 0;
    while (ack != level && n < 20) begin
      @(posedge clk);
      #1 n++;
    end
    if (ack != level) begin
      stop_with_failure($sformatf("ack did not reach %0d within 20 cycles", level));
    end
    check_hex("ack edge count", 64'(n), 64'(exp_edges));
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [63:0] data);
    csr_we = 1'b1;
    csr_addr = addr;
    csr_wdata = data;
    @(posedge clk);
    #1 csr_we = 1'b0;
  endtask

  task automatic csr_read(input logic [11:0] addr, output logic [63:0] data);
    csr_addr = addr;
    @(posedge clk);
    #1 data = csr_rdata;
  endtask

  task automatic expect_csr(input string name, input logic [11:0] addr, input logic [63:0] exp);
    logic [63:0] got;
    csr_read(addr, got);
    check_hex(name, got, exp);
  endtask

  task automatic write_readback(input string name, input logic [11:0] addr);
    logic [63:0] val;
    val = {$random(seed), $random(seed)};
    csr_write(addr, val);
    expect_csr(name, addr, val);
  endtask

  // one four-phase handshake returning the redirect seen while ack is high
  task automatic run_request(input trap_kind_e k, input logic [11:0] fl, input logic [63:0] t_pc,
                             input logic [31:0] t_inst, input logic [63:0] t_addr,
                             output logic valid, output logic [63:0] pc_out);
    trap = '{kind: k, flags: exc_flags_t'(fl), pc: t_pc, inst: t_inst, addr: t_addr};
    req = 1'b1;
    wait_ack(1'b1, 2);
    valid = redirect_valid;
    pc_out = redirect_pc;
    req = 1'b0;
    wait_ack(1'b0, 1);
  endtask

  // trap entry against the priority table and the tval source rule
  task automatic enter_and_check(input logic [11:0] fl, input logic [3:0] irq_code,
                                 input logic [63:0] st, input logic [63:0] tvec);
    logic [63:0] pc, addr, cause, tval, exp_pc, pc_out;
    logic [31:0] inst;
    logic        valid;
    int          idx;
    pc = {$random(seed), $random(seed)};
    addr = {$random(seed), $random(seed)};
    inst = $random(seed);
    csr_write(CSR_MSTATUS, st);
    idx = -1;
    for (int i = 0; i < 12; i++) begin
      if (fl[i]) idx = i;
    end
    cause = {1'b1, 59'h0, irq_code};
    tval = 64'h0;
    exp_pc = {tvec[63:2], 2'b00};
    if (idx < 0 && tvec[0]) exp_pc = exp_pc + {58'h0, irq_code, 2'b00};
    if (idx >= 0) cause = {60'h0, CODE_TBL[idx*4 +: 4]};
    // fetch faults give pc, illegal inst gives the word, memory faults the address
    if (idx >= 9) tval = pc;
    else if (idx == 8) tval = {32'h0, inst};
    else if (idx >= 0 && idx <= 5) tval = addr;
    run_request(TRAP_ENTER, fl, pc, inst, addr, valid, pc_out);
    check_hex("redirect_valid", 64'(valid), 64'h1);
    check_hex("redirect_pc", pc_out, exp_pc);
    expect_csr("mcause", CSR_MCAUSE, cause);
    expect_csr("mepc", CSR_MEPC, pc);
    expect_csr("mtval", CSR_MTVAL, tval);
    expect_csr("mstatus", CSR_MSTATUS, (st & ~64'h88) | (64'(st[3]) << 7));
  endtask

  task automatic interrupt_case(input logic [2:0] lines, input logic [11:0] fl,
                                input logic [3:0] code, input logic [63:0] tvec);
    irq = lines;
    enter_and_check(fl, code, 64'h8, tvec);
  endtask

  // mret restores MIE from MPIE, sets MPIE and jumps to mepc
  task automatic return_and_check(input logic [63:0] st);
    logic [63:0] epc, pc_out;
    logic        valid;
    epc = {$random(seed), $random(seed)};
    csr_write(CSR_MEPC, epc);
    csr_write(CSR_MSTATUS, st);
    run_request(TRAP_RETURN, 12'h0, 64'h0, 32'h0, 64'h0, valid, pc_out);
    check_hex("redirect_valid", 64'(valid), 64'h1);
    check_hex("redirect_pc", pc_out, epc);
    expect_csr("mstatus", CSR_MSTATUS, (st & ~64'h88) | 64'h80 | (64'(st[7]) << 3));
  endtask

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    trap = '0;
    irq = 3'b000;
    csr_we = 1'b0;
    csr_addr = 12'h0;
    csr_wdata = 64'h0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    check_hex("ack", 64'(ack), 64'h0);
    check_hex("redirect_valid", 64'(redirect_valid), 64'h0);
    expect_csr("mstatus", CSR_MSTATUS, 64'h0);
    expect_csr("mtvec", CSR_MTVEC, 64'h0);
    expect_csr("mie", CSR_MIE, 64'h0);

    // software port writes and readbacks
    write_readback("mtvec", CSR_MTVEC);
    write_readback("mie", CSR_MIE);
    write_readback("mstatus", CSR_MSTATUS);
    write_readback("mepc", CSR_MEPC);
    // mip only follows the irq lines
    csr_write(CSR_MIP, '1);
    check_hex("mip", csr_rdata, 64'h0);

    // single then mixed exception flags in direct mode
    base = {$random(seed), $random(seed)};
    base[1:0] = 2'b00;
    csr_write(CSR_MTVEC, base);
    csr_write(CSR_MIE, 64'h0);
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      flags = (i < 12) ? (12'h1 << i) : rnd[11:0];
      if (flags == 12'h0) flags = 12'h800;
      enter_and_check(flags, 4'd0, {$random(seed), $random(seed)}, base);
    end

    // arbitration in direct then vectored mode with ecall beating all lines
    csr_write(CSR_MIE, 64'h888);
    for (int m = 0; m < 2; m++) begin
      csr_write(CSR_MTVEC, base | 64'(m));
      interrupt_case(3'b111, 12'h0, 4'd11, base | 64'(m));
      interrupt_case(3'b011, 12'h0, 4'd3, base | 64'(m));
      interrupt_case(3'b010, 12'h0, 4'd7, base | 64'(m));
      interrupt_case(3'b111, 12'h040, 4'd0, base | 64'(m));
    end
    expect_csr("mip", CSR_MIP, 64'h888);

    // masked by mstatus.MIE and then by mie
    csr_write(CSR_MSTATUS, 64'h0);
    run_request(TRAP_ENTER, 12'h0, 64'h100, 32'h0, 64'h0, rv, rd);
    check_hex("redirect_valid", 64'(rv), 64'h0);
    csr_write(CSR_MSTATUS, 64'h8);
    csr_write(CSR_MIE, 64'h0);
    run_request(TRAP_ENTER, 12'h0, 64'h100, 32'h0, 64'h0, rv, rd);
    check_hex("redirect_valid", 64'(rv), 64'h0);

    return_and_check(64'h80);
    return_and_check(64'h8);
    return_and_check({$random(seed), $random(seed)});

    // software mepc write on the commit edge loses to the trap update
    rd = {$random(seed), $random(seed)};
    trap = '{kind: TRAP_ENTER, flags: exc_flags_t'(12'h100), pc: rd,
             inst: 32'h0, addr: 64'h0};
    req = 1'b1;
    @(posedge clk);
    #1 csr_we = 1'b1;
    csr_addr = CSR_MEPC;
    csr_wdata = ~rd;
    @(posedge clk);
    #1 csr_we = 1'b0;
    check_hex("ack", 64'(ack), 64'h1);
    // req held high keeps the unit in ACK while mtvec moves underneath
    csr_write(CSR_MTVEC, ~base);
    repeat (2) @(posedge clk);
    #1 check_hex("ack", 64'(ack), 64'h1);
    req = 1'b0;
    wait_ack(1'b0, 1);
    expect_csr("mepc", CSR_MEPC, rd);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* flist.f */
design/trap_pkg.sv
design/excp_cause_decoder.sv
design/itrp_arbiter.sv
design/trap_controller.sv
design/machine_csr_file.sv
design/trap_unit_top.sv
dv/tb_trap_unit.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_trap_unit -f flist.f -o sim_trap_unit \
  && ./obj_dir/sim_trap_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
